// File: src/oddpipe_macros.svh
`ifndef ODDPIPE_MACROS_SVH
`define ODDPIPE_MACROS_SVH

// operand and field widths
`define QUAD_W           128
`define WORD_W           32
`define REG_ADDR_W       7
`define I7_W             7
`define I16_W            16

// writeback record fields
`define LAT_W            4
`define UNIT_W           3

// unit latencies as reported in the writeback record
`define PERMUTE_LATENCY  4
`define BRANCH_LATENCY   1

// result stages between the issue register and the result port
`define ODD_PIPE_DEPTH   7

// local-store limit applied to every program counter
`define LSLR             32'h0003FFFF

`endif

// File: src/oddpipe_pkg.sv
`include "oddpipe_macros.svh"

package oddpipe_pkg;

    // no-operation is code 0 so an idle issue word decodes to it
    typedef enum logic [4:0] {
        NO_OPERATION,
        SHIFT_LEFT_QUADWORD_BY_BITS,
        SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE,
        SHIFT_LEFT_QUADWORD_BY_BYTES,
        SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE,
        SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT,
        ROTATE_QUADWORD_BY_BYTES,
        ROTATE_QUADWORD_BY_BYTES_IMMEDIATE,
        ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT,
        ROTATE_QUADWORD_BY_BITS,
        ROTATE_QUADWORD_BY_BITS_IMMEDIATE,
        GATHER_BITS_FROM_BYTES,
        GATHER_BITS_FROM_HALFWORDS,
        GATHER_BITS_FROM_WORDS,
        BRANCH_RELATIVE,
        BRANCH_ABSOLUTE,
        BRANCH_RELATIVE_AND_SET_LINK,
        BRANCH_ABSOLUTE_AND_SET_LINK,
        BRANCH_IF_NOT_ZERO_WORD,
        BRANCH_IF_ZERO_WORD,
        BRANCH_IF_NOT_ZERO_HALFWORD,
        BRANCH_IF_ZERO_HALFWORD
    } opcode_e;

    // unit ids carried in the writeback record
    typedef enum logic [`UNIT_W-1:0] {
        UNIT_NONE    = 0,
        UNIT_PERMUTE = 5,
        UNIT_BRANCH  = 7
    } unit_e;

    // one issued instruction, bit 0 is the msb of every field
    typedef struct packed {
        opcode_e                opcode;
        logic [0:`QUAD_W-1]     ra;
        logic [0:`QUAD_W-1]     rb;
        logic [0:`QUAD_W-1]     rt;
        logic [0:`REG_ADDR_W-1] rt_address;
        logic [0:`I7_W-1]       i7;
        logic [0:`I16_W-1]      i16;
        logic [0:`WORD_W-1]     pc;
    } issue_t;

    typedef struct packed {
        unit_e                  unit_id;
        logic [0:`QUAD_W-1]     rt_value;
        logic                   write_enable;
        logic [0:`REG_ADDR_W-1] rt_address;
        logic [0:`LAT_W-1]      latency;
    } writeback_t;

    typedef struct packed {
        logic                   valid;
        logic                   branch_taken;
        logic [0:`WORD_W-1]     pc_next;
    } redirect_t;

endpackage

// File: src/permute_unit.sv
`timescale 1ns/1ns

`include "oddpipe_macros.svh"

module permute_unit
    import oddpipe_pkg::*;
(
    input  issue_t     op,
    output logic       hit,
    output writeback_t wb
);

    logic [0:`QUAD_W-1] value;
    logic [0:15]        gather_b;
    logic [0:7]         gather_h;
    logic [0:3]         gather_w;

    // byte counts of 16 and up push every byte out
    function automatic logic [0:`QUAD_W-1] shift_bytes(
        input logic [0:`QUAD_W-1] q,
        input logic [4:0]         n
    );
        return q << {n, 3'b000};
    endfunction

    function automatic logic [0:`QUAD_W-1] rotate_bytes(
        input logic [0:`QUAD_W-1] q,
        input logic [3:0]         n
    );
        return (q << {n, 3'b000}) | (q >> (`QUAD_W - {n, 3'b000}));
    endfunction

    function automatic logic [0:`QUAD_W-1] rotate_bits(
        input logic [0:`QUAD_W-1] q,
        input logic [2:0]         n
    );
        return (q << n) | (q >> (`QUAD_W - n));
    endfunction

    // lsb of each element, element 0 ends up most significant
    always_comb
    begin
        for (int j = 0; j < 16; j++)
        begin
            gather_b[j] = op.ra[j * 8 + 7];
        end
        for (int j = 0; j < 8; j++)
        begin
            gather_h[j] = op.ra[j * 16 + 15];
        end
        for (int j = 0; j < 4; j++)
        begin
            gather_w[j] = op.ra[j * 32 + 31];
        end
    end

    // counts come from the rb preferred word or from i7
    always_comb
    begin
        hit   = 1'b1;
        value = '0;
        case (op.opcode)
            SHIFT_LEFT_QUADWORD_BY_BITS:
                value = op.ra << op.rb[29:31];
            SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE:
                value = op.ra << op.i7[4:6];
            SHIFT_LEFT_QUADWORD_BY_BYTES:
                value = shift_bytes(op.ra, op.rb[27:31]);
            SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE:
                value = shift_bytes(op.ra, op.i7[2:6]);
            SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT:
                value = shift_bytes(op.ra, op.rb[24:28]);
            ROTATE_QUADWORD_BY_BYTES:
                value = rotate_bytes(op.ra, op.rb[28:31]);
            ROTATE_QUADWORD_BY_BYTES_IMMEDIATE:
                value = rotate_bytes(op.ra, op.i7[3:6]);
            // bits 24-28 taken modulo 16
            ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT:
                value = rotate_bytes(op.ra, op.rb[25:28]);
            ROTATE_QUADWORD_BY_BITS:
                value = rotate_bits(op.ra, op.rb[29:31]);
            ROTATE_QUADWORD_BY_BITS_IMMEDIATE:
                value = rotate_bits(op.ra, op.i7[4:6]);
            GATHER_BITS_FROM_BYTES:
                value[16:31] = gather_b;
            GATHER_BITS_FROM_HALFWORDS:
                value[24:31] = gather_h;
            GATHER_BITS_FROM_WORDS:
                value[28:31] = gather_w;
            default:
                hit = 1'b0;
        endcase
    end

    assign wb.unit_id      = UNIT_PERMUTE;
    assign wb.rt_value     = value;
    assign wb.write_enable = 1'b1;
    assign wb.rt_address   = op.rt_address;
    assign wb.latency      = `LAT_W'(`PERMUTE_LATENCY);

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ns

`include "oddpipe_macros.svh"

module branch_unit
    import oddpipe_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       valid,
    input  issue_t     op,
    output logic       hit,
    output writeback_t wb,
    output redirect_t  redirect
);

    logic [0:`WORD_W-1] offset;
    logic [0:`WORD_W-1] rel_target;
    logic [0:`WORD_W-1] abs_target;
    logic [0:`WORD_W-1] cond_target;
    logic [0:`WORD_W-1] link;
    logic [0:`WORD_W-1] target;
    logic               word_zero;
    logic               half_zero;
    logic               taken;
    logic               set_link;
    logic               redirect_valid;
    logic               redirect_taken;
    logic [0:`WORD_W-1] redirect_pc;

    // i16 counts words
    assign offset      = {{14{op.i16[0]}}, op.i16, 2'b00};
    assign rel_target  = (op.pc + offset) & `LSLR;
    assign abs_target  = offset & `LSLR;
    assign cond_target = rel_target & 32'hFFFF_FFFC;
    assign link        = (op.pc + 32'd4) & `LSLR;

    // conditions look at the rt operand, not at a result
    assign word_zero = (op.rt[0:31] == '0);
    assign half_zero = (op.rt[16:31] == '0);

    always_comb
    begin
        hit      = 1'b1;
        taken    = 1'b1;
        set_link = 1'b0;
        target   = rel_target;
        case (op.opcode)
            BRANCH_RELATIVE:
                target = rel_target;
            BRANCH_ABSOLUTE:
                target = abs_target;
            BRANCH_RELATIVE_AND_SET_LINK:
                set_link = 1'b1;
            BRANCH_ABSOLUTE_AND_SET_LINK:
            begin
                target   = abs_target;
                set_link = 1'b1;
            end
            BRANCH_IF_NOT_ZERO_WORD:
            begin
                taken  = !word_zero;
                target = cond_target;
            end
            BRANCH_IF_ZERO_WORD:
            begin
                taken  = word_zero;
                target = cond_target;
            end
            BRANCH_IF_NOT_ZERO_HALFWORD:
            begin
                taken  = !half_zero;
                target = cond_target;
            end
            BRANCH_IF_ZERO_HALFWORD:
            begin
                taken  = half_zero;
                target = cond_target;
            end
            default:
            begin
                hit   = 1'b0;
                taken = 1'b0;
            end
        endcase
        // fall through to the next instruction
        if (!taken)
        begin
            target = link;
        end
    end

    // link address lands in the preferred word
    assign wb.unit_id      = UNIT_BRANCH;
    assign wb.rt_value     = set_link ? {link, {(`QUAD_W - `WORD_W){1'b0}}} : '0;
    assign wb.write_enable = set_link;
    assign wb.rt_address   = op.rt_address;
    assign wb.latency      = `LAT_W'(`BRANCH_LATENCY);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            redirect_valid <= 1'b0;
        end
        else
        begin
            redirect_valid <= valid && hit;
        end
    end

    always_ff @(posedge clock)
    begin
        redirect_taken <= taken;
        redirect_pc    <= target;
    end

    assign redirect = '{valid: redirect_valid, branch_taken: redirect_taken,
                        pc_next: redirect_pc};

    // a taken branch always lands on a word boundary
    assert property (@(posedge clock) disable iff (reset)
        redirect.valid && redirect.branch_taken
        |-> redirect.pc_next[30:31] == 2'b00);

endmodule

// File: src/result_pipe.sv
`timescale 1ns/1ns

`include "oddpipe_macros.svh"

module result_pipe
    import oddpipe_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       valid,
    input  logic       permute_hit,
    input  writeback_t permute_wb,
    input  logic       branch_hit,
    input  writeback_t branch_wb,
    output logic       result_valid,
    output writeback_t result
);

    writeback_t                  entry;
    writeback_t                  stage_wb [0:`ODD_PIPE_DEPTH-1];
    logic [0:`ODD_PIPE_DEPTH-1]  stage_v;

    always_comb
    begin
        if (permute_hit)
        begin
            entry = permute_wb;
        end
        else if (branch_hit)
        begin
            entry = branch_wb;
        end
        else
        begin
            // no-operation keeps only its target address
            entry            = '0;
            entry.rt_address = permute_wb.rt_address;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stage_v <= '0;
        end
        else
        begin
            stage_v <= {valid, stage_v[0:`ODD_PIPE_DEPTH-2]};
        end
    end

    always_ff @(posedge clock)
    begin
        stage_wb[0] <= entry;
        for (int i = 1; i < `ODD_PIPE_DEPTH; i++)
        begin
            stage_wb[i] <= stage_wb[i-1];
        end
    end

    assign result_valid = stage_v[`ODD_PIPE_DEPTH-1];
    assign result       = stage_wb[`ODD_PIPE_DEPTH-1];

    // the two units decode disjoint opcode sets
    assert property (@(posedge clock) disable iff (reset)
        valid |-> !(permute_hit && branch_hit));

    assert property (@(posedge clock) disable iff (reset)
        result_valid && result.write_enable
        |-> result.unit_id inside {UNIT_PERMUTE, UNIT_BRANCH});

endmodule

// File: src/oddpipe.sv
`timescale 1ns/1ns

`include "oddpipe_macros.svh"

module oddpipe
    import oddpipe_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       issue_valid,
    input  issue_t     issue,
    output logic       result_valid,
    output writeback_t result,
    output redirect_t  redirect
);

    logic       stage_valid;
    issue_t     stage;
    logic       permute_hit;
    logic       branch_hit;
    writeback_t permute_wb;
    writeback_t branch_wb;

    // issue register, one instruction per cycle with no stall
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stage_valid <= 1'b0;
        end
        else
        begin
            stage_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock)
    begin
        stage <= issue;
    end

    permute_unit u_permute_unit (
        .op  (stage),
        .hit (permute_hit),
        .wb  (permute_wb)
    );

    branch_unit u_branch_unit (
        .clock    (clock),
        .reset    (reset),
        .valid    (stage_valid),
        .op       (stage),
        .hit      (branch_hit),
        .wb       (branch_wb),
        .redirect (redirect)
    );

    // both records enter here, whichever unit claimed the opcode wins
    result_pipe u_result_pipe (
        .clock        (clock),
        .reset        (reset),
        .valid        (stage_valid),
        .permute_hit  (permute_hit),
        .permute_wb   (permute_wb),
        .branch_hit   (branch_hit),
        .branch_wb    (branch_wb),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// File: bench/oddpipe_tests.svh
function automatic logic [127:0] random_quad();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
endfunction

function automatic issue_t random_issue(input opcode_e opc);
    issue_t op;
    op.opcode     = opc;
    op.ra         = random_quad();
    op.rb         = random_quad();
    op.rt         = random_quad();
    op.rt_address = 7'($random(seed));
    op.i7         = 7'($random(seed));
    op.i16        = 16'($random(seed));
    // word-aligned program counter inside the local store
    op.pc         = 32'($random(seed)) & `LSLR & 32'hFFFF_FFFC;
    return op;
endfunction

// bit i moves to bit i+n, wrapping at the top
function automatic logic [127:0] rotate_left(input logic [127:0] q, input int n);
    logic [127:0] r;
    for (int i = 0; i < 128; i++)
    begin
        r[(i + n) % 128] = q[i];
    end
    return r;
endfunction

function automatic logic [127:0] byte_shift(input logic [127:0] q, input int n);
    return (n >= 16) ? 128'b0 : q << (8 * n);
endfunction

// element j lsb goes to preferred word bit (m-1-j), counted from its lsb
function automatic logic [127:0] gather_lsbs(input logic [127:0] q, input int w);
    logic [127:0] r;
    int           m;
    m = 128 / w;
    r = '0;
    for (int j = 0; j < m; j++)
    begin
        r[96 + m - 1 - j] = q[128 - w * (j + 1)];
    end
    return r;
endfunction

function automatic logic [127:0] permute_model(input issue_t op);
    logic [127:0] ra;
    logic [31:0]  pw;
    logic [6:0]   imm;
    ra  = op.ra;
    pw  = op.rb[0:31];
    imm = op.i7;
    case (op.opcode)
        SHIFT_LEFT_QUADWORD_BY_BITS:                       return ra << pw[2:0];
        SHIFT_LEFT_QUADWORD_BY_BITS_IMMEDIATE:             return ra << imm[2:0];
        SHIFT_LEFT_QUADWORD_BY_BYTES:                      return byte_shift(ra, pw[4:0]);
        SHIFT_LEFT_QUADWORD_BY_BYTE_IMMEDIATE:             return byte_shift(ra, imm[4:0]);
        SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT: return byte_shift(ra, pw[7:3]);
        ROTATE_QUADWORD_BY_BYTES:                       return rotate_left(ra, 8 * pw[3:0]);
        ROTATE_QUADWORD_BY_BYTES_IMMEDIATE:             return rotate_left(ra, 8 * imm[3:0]);
        ROTATE_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT:
            return rotate_left(ra, 8 * (pw[7:3] % 16));
        ROTATE_QUADWORD_BY_BITS:                        return rotate_left(ra, pw[2:0]);
        ROTATE_QUADWORD_BY_BITS_IMMEDIATE:              return rotate_left(ra, imm[2:0]);
        GATHER_BITS_FROM_BYTES:                         return gather_lsbs(ra, 8);
        GATHER_BITS_FROM_HALFWORDS:                     return gather_lsbs(ra, 16);
        GATHER_BITS_FROM_WORDS:                         return gather_lsbs(ra, 32);
        default:                                        return 128'b0;
    endcase
endfunction

function automatic redirect_t redirect_model(input issue_t op);
    redirect_t   rd;
    logic [31:0] offset;
    logic [31:0] rel;
    logic [31:0] link;
    logic [31:0] word;
    logic [15:0] half;
    offset = {{16{op.i16[0]}}, op.i16} * 4;
    rel    = (op.pc + offset) & `LSLR;
    link   = (op.pc + 32'd4) & `LSLR;
    word   = op.rt[0:31];
    half   = op.rt[16:31];
    rd     = '{valid: 1'b1, branch_taken: 1'b1, pc_next: {rel[31:2], 2'b00}};
    case (op.opcode)
        BRANCH_RELATIVE, BRANCH_RELATIVE_AND_SET_LINK: rd.pc_next = rel;
        BRANCH_ABSOLUTE, BRANCH_ABSOLUTE_AND_SET_LINK: rd.pc_next = offset & `LSLR;
        BRANCH_IF_NOT_ZERO_WORD:     rd.branch_taken = (word != 0);
        BRANCH_IF_ZERO_WORD:         rd.branch_taken = (word == 0);
        BRANCH_IF_NOT_ZERO_HALFWORD: rd.branch_taken = (half != 0);
        BRANCH_IF_ZERO_HALFWORD:     rd.branch_taken = (half == 0);
        default:                     rd = '0;
    endcase
    if (rd.valid && !rd.branch_taken)
    begin
        rd.pc_next = link;
    end
    return rd;
endfunction

function automatic writeback_t writeback_model(input issue_t op);
    writeback_t  wb;
    redirect_t   rd;
    logic [31:0] link;
    wb            = '0;
    wb.rt_address = op.rt_address;
    link          = (op.pc + 32'd4) & `LSLR;
    rd            = redirect_model(op);
    if (op.opcode >= SHIFT_LEFT_QUADWORD_BY_BITS && op.opcode <= GATHER_BITS_FROM_WORDS)
    begin
        wb.unit_id      = UNIT_PERMUTE;
        wb.rt_value     = permute_model(op);
        wb.write_enable = 1'b1;
        wb.latency      = `LAT_W'(`PERMUTE_LATENCY);
    end
    else if (rd.valid)
    begin
        wb.unit_id = UNIT_BRANCH;
        wb.latency = `LAT_W'(`BRANCH_LATENCY);
        if (op.opcode == BRANCH_RELATIVE_AND_SET_LINK || op.opcode == BRANCH_ABSOLUTE_AND_SET_LINK)
        begin
            wb.write_enable = 1'b1;
            wb.rt_value     = {link, 96'b0};
        end
    end
    return wb;
endfunction

task automatic run_opcode_range(input int first, input int last);
    issue_t ops[$];
    for (int r = 0; r < RANDOM_ROUNDS; r++)
    begin
        for (int k = first; k <= last; k++)
        begin
            ops.push_back(random_issue(opcode_e'(k)));
        end
    end
    run_stream(ops);
endtask

task automatic test_shifts();
    run_opcode_range(SHIFT_LEFT_QUADWORD_BY_BITS, SHIFT_LEFT_QUADWORD_BY_BYTES_FROM_BIT_SHIFT_COUNT);
endtask

task automatic test_rotates();
    run_opcode_range(ROTATE_QUADWORD_BY_BYTES, ROTATE_QUADWORD_BY_BITS_IMMEDIATE);
endtask

task automatic test_gathers();
    run_opcode_range(GATHER_BITS_FROM_BYTES, GATHER_BITS_FROM_WORDS);
endtask

task automatic test_unconditional_branches();
    run_opcode_range(BRANCH_RELATIVE, BRANCH_ABSOLUTE_AND_SET_LINK);
endtask

// each form sees a zero and a nonzero rt
// halfword zeros keep a random upper half
task automatic test_conditional_branches();
    issue_t ops[$];
    issue_t op;
    for (int r = 0; r < RANDOM_ROUNDS; r++)
    begin
        for (int k = BRANCH_IF_NOT_ZERO_WORD; k <= BRANCH_IF_ZERO_HALFWORD; k++)
        begin
            for (int zero = 0; zero < 2; zero++)
            begin
                op = random_issue(opcode_e'(k));
                // low pc bits make the target alignment visible
                op.pc[30:31] = 2'($random(seed));
                if (zero == 1)
                begin
                    op.rt[16:31] = '0;
                    if (k <= BRANCH_IF_ZERO_WORD)
                    begin
                        op.rt[0:15] = '0;
                    end
                end
                else if (k <= BRANCH_IF_ZERO_WORD)
                begin
                    // word is nonzero only in its upper half
                    op.rt[16:31] = '0;
                    op.rt[0]     = 1'b1;
                end
                else
                begin
                    op.rt[31] = 1'b1;
                end
                ops.push_back(op);
            end
        end
    end
    run_stream(ops);
endtask

task automatic test_back_to_back();
    issue_t  ops[$];
    opcode_e mix [7];
    mix = '{SHIFT_LEFT_QUADWORD_BY_BITS, BRANCH_RELATIVE_AND_SET_LINK, NO_OPERATION,
            ROTATE_QUADWORD_BY_BYTES, BRANCH_IF_ZERO_WORD, GATHER_BITS_FROM_WORDS,
            BRANCH_ABSOLUTE};
    foreach (mix[i])
    begin
        ops.push_back(random_issue(mix[i]));
    end
    run_stream(ops);
endtask

// File: bench/oddpipe_tb.sv
`timescale 1ns/1ns

`include "oddpipe_macros.svh"

module oddpipe_tb
    import oddpipe_pkg::*;
();

    localparam int CLOCK_PERIOD  = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 3;
    localparam int RANDOM_ROUNDS = 4;
    localparam int NUM_TESTS     = 6;
    // shifts, rotates, gathers, unconditional, conditional, then the mixed burst
    localparam int NUM_ISSUED    = RANDOM_ROUNDS * (5 + 5 + 3 + 4 + 8) + 7;
    // every test drains the result pipe once
    localparam int WATCHDOG_CYCLES = NUM_ISSUED + NUM_TESTS * `ODD_PIPE_DEPTH
                                     + RESET_CYCLES + 20;

    logic       clock;
    logic       reset;
    logic       issue_valid;
    issue_t     issue;
    logic       result_valid;
    writeback_t result;
    redirect_t  redirect;

    int seed = 32'hade7;

    oddpipe u_oddpipe (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .result_valid (result_valid),
        .result       (result),
        .redirect     (redirect)
    );

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    task automatic tick();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic check_equal(input logic [159:0] actual, input logic [159:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // issues back to back; instruction k redirects at c = k+1 and retires at c = k+7
    task automatic run_stream(input issue_t ops[$]);
        int         n;
        redirect_t  exp_rd;
        writeback_t exp_wb;
        n = ops.size();
        for (int c = 0; c < n + `ODD_PIPE_DEPTH; c++)
        begin
            issue_valid = (c < n);
            if (c < n)
            begin
                issue = ops[c];
            end
            tick();
            exp_rd = '0;
            if (c >= 1 && c <= n)
            begin
                exp_rd = redirect_model(ops[c-1]);
            end
            check_equal(redirect.valid, exp_rd.valid, $sformatf("redirect valid, cycle %0d", c));
            if (exp_rd.valid)
            begin
                check_equal(redirect, exp_rd, $sformatf("redirect of instruction %0d", c - 1));
            end
            if (c >= `ODD_PIPE_DEPTH)
            begin
                exp_wb = writeback_model(ops[c - `ODD_PIPE_DEPTH]);
                check_equal(result_valid, 1'b1, $sformatf("result valid, cycle %0d", c));
                check_equal(result, exp_wb,
                            $sformatf("result of instruction %0d", c - `ODD_PIPE_DEPTH));
            end
            else
            begin
                check_equal(result_valid, 1'b0, $sformatf("idle result, cycle %0d", c));
            end
        end
    endtask

    `include "oddpipe_tests.svh"

    initial
    begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (RESET_CYCLES) tick();
        check_equal(result_valid, 1'b0, "result valid after reset");
        check_equal(redirect.valid, 1'b0, "redirect valid after reset");
        reset = 1'b0;
        test_shifts();
        test_rotates();
        test_gathers();
        test_unconditional_branches();
        test_conditional_branches();
        test_back_to_back();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: oddpipe.f
+incdir+src
+incdir+bench
src/oddpipe_pkg.sv
src/permute_unit.sv
src/branch_unit.sv
src/result_pipe.sv
src/oddpipe.sv
bench/oddpipe_tb.sv

// File: run.sh
#!/bin/sh
# build the odd pipe testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module oddpipe_tb \
    -f oddpipe.f \
    -o oddpipe_sim

./obj_dir/oddpipe_sim
